// ==== verilog/vmem_pkg.sv ====
package vmem_pkg;

   // bus widths seen on the AXI side
   localparam int MEM_ADDR_W = 32;
   localparam int MEM_DATA_W = 32;
   localparam int AXI_LEN_W  = 8;

   // byte address on the AXI bus
   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

   // one bus word, also one vector element
   typedef logic [MEM_DATA_W-1:0] mem_data_t;

   // AXI burst length field, beats minus one
   typedef logic [AXI_LEN_W-1:0] axi_len_t;

endpackage : vmem_pkg

// ==== verilog/vinstr_pkg.sv ====
package vinstr_pkg;

   // field widths of a load/store instruction
   localparam int VREG_IDX_W = 3;
   localparam int VEL_IDX_W  = 3;
   localparam int VLEN_W     = 4;

   // memory direction of the move
   typedef enum logic [0:0] {
      VOP_LOAD  = 1'b0,
      VOP_STORE = 1'b1
   } vop_t;

   // vector register number
   typedef logic [VREG_IDX_W-1:0] vreg_idx_t;

   // element inside one register
   typedef logic [VEL_IDX_W-1:0] vel_idx_t;

   // active length, 1 up to VLMAX
   typedef logic [VLEN_W-1:0] vlen_t;

endpackage : vinstr_pkg

// ==== verilog/vec_burst_if.sv ====
`timescale 1ns/1ps

interface vec_burst_if;

   // request side, from the load/store controller
   logic                req;
   logic                write;
   vmem_pkg::mem_addr_t addr;
   vmem_pkg::axi_len_t  len;
   vmem_pkg::mem_data_t wdata;

   // progress side, from the AXI master
   logic                wnext;
   vmem_pkg::mem_data_t rdata;
   logic                rnext;
   logic                fin;

   modport ctrl (
      output req, write, addr, len, wdata,
      input  wnext, rdata, rnext, fin
   );

   modport master (
      input  req, write, addr, len, wdata,
      output wnext, rdata, rnext, fin
   );

endinterface : vec_burst_if

// ==== verilog/vreg_port_if.sv ====
`timescale 1ns/1ps

interface vreg_port_if;

   vinstr_pkg::vreg_idx_t vreg;
   vinstr_pkg::vel_idx_t  vel;
   logic                  we;
   vmem_pkg::mem_data_t   wdata;
   // combinational read of vreg/vel
   vmem_pkg::mem_data_t   rdata;

   modport ctrl (
      output vreg, vel, we, wdata,
      input  rdata
   );

   modport bank (
      input  vreg, vel, we, wdata,
      output rdata
   );

endinterface : vreg_port_if

// ==== verilog/vec_cfg_regs.sv ====
`timescale 1ns/1ps

module vec_cfg_regs #(
   parameter int VLMAX = 8
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cfg_we,
   input  vinstr_pkg::vlen_t cfg_vlen,
   input  logic              busy,
   input  logic              drop,
   output vinstr_pkg::vlen_t vlen,
   output logic              dropped
);

   import vinstr_pkg::*;

   vlen_t vlen_wr;

   // keep a written length inside 1..VLMAX
   always_comb begin
      if (cfg_vlen == '0) begin
         vlen_wr = vlen_t'(1);
      end else if (cfg_vlen > vlen_t'(VLMAX)) begin
         vlen_wr = vlen_t'(VLMAX);
      end else begin
         vlen_wr = cfg_vlen;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vlen    <= vlen_t'(VLMAX);
         dropped <= 1'b0;
      end else begin
         // length only moves between instructions
         if (cfg_we && !busy) begin
            vlen <= vlen_wr;
         end
         // sticky until reset
         if (drop) begin
            dropped <= 1'b1;
         end
      end
   end

   a_vlen_range : assert property (@(posedge clk) disable iff (!rst_n)
      (vlen >= vlen_t'(1)) && (vlen <= vlen_t'(VLMAX)));

endmodule : vec_cfg_regs

// ==== verilog/vec_reg_bank.sv ====
`timescale 1ns/1ps

module vec_reg_bank #(
   parameter int NUM_VREGS = 8,
   parameter int VLMAX     = 8
) (
   input logic  clk,
   input logic  rst_n,
   vreg_port_if.bank vp
);

   import vmem_pkg::*;

   // element storage, register by element
   mem_data_t regs [NUM_VREGS][VLMAX];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int r = 0; r < NUM_VREGS; r++) begin
            for (int e = 0; e < VLMAX; e++) begin
               regs[r][e] <= '0;
            end
         end
      end else if (vp.we) begin
         regs[vp.vreg][vp.vel] <= vp.wdata;
      end
   end

   // read port has no latency, the controller streams stores from it
   assign vp.rdata = regs[vp.vreg][vp.vel];

   // the controller must keep its write enable quiet while reset is held
   a_no_we_in_reset : assert property (@(posedge clk)
      !rst_n |=> (!rst_n -> !vp.we));

endmodule : vec_reg_bank

// ==== verilog/vec_lsu_ctrl.sv ====
`timescale 1ns/1ps

module vec_lsu_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  instr_valid,
   input  vinstr_pkg::vop_t      instr_op,
   input  vinstr_pkg::vreg_idx_t instr_vreg,
   input  vmem_pkg::mem_addr_t   instr_addr,
   input  vinstr_pkg::vlen_t     vlen,
   output logic                  busy,
   output logic                  done,
   output logic                  drop,
   vreg_port_if.ctrl             vp,
   vec_burst_if.ctrl             bp
);

   import vmem_pkg::*;
   import vinstr_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      BURST,
      FINISH
   } lsu_state_t;

   lsu_state_t state;
   logic       accept;
   logic       step;
   logic       req_q;
   vel_idx_t   el_q;
   vop_t       op_q;
   vreg_idx_t  vreg_q;
   mem_addr_t  addr_q;
   vlen_t      len_q;

   // busy low in IDLE and FINISH, so a new move may start right after done
   assign busy   = (state == BURST);
   assign done   = (state == FINISH);
   assign accept = instr_valid && !busy;
   assign drop   = instr_valid && busy;

   // element pointer follows the beats of the burst
   assign step = (op_q == VOP_LOAD) ? bp.rnext : bp.wnext;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= IDLE;
         req_q <= 1'b0;
         el_q  <= '0;
      end else begin
         req_q <= 1'b0;
         case (state)
            IDLE, FINISH: begin
               if (accept) begin
                  state <= BURST;
                  req_q <= 1'b1;
                  el_q  <= '0;
               end else begin
                  state <= IDLE;
               end
            end
            BURST: begin
               if (step) begin
                  el_q <= el_q + 1'b1;
               end
               if (bp.fin) begin
                  state <= FINISH;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // instruction fields, captured once per move
   always_ff @(posedge clk) begin
      if (accept) begin
         op_q   <= instr_op;
         vreg_q <= instr_vreg;
         addr_q <= instr_addr;
         len_q  <= vlen;
      end
   end

   assign bp.req   = req_q;
   assign bp.write = (op_q == VOP_STORE);
   assign bp.addr  = addr_q;
   assign bp.len   = axi_len_t'(len_q) - axi_len_t'(1);
   assign bp.wdata = vp.rdata;

   assign vp.vreg  = vreg_q;
   assign vp.vel   = el_q;
   assign vp.we    = (state == BURST) && (op_q == VOP_LOAD) && bp.rnext;
   assign vp.wdata = bp.rdata;

   a_addr_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      accept |-> (instr_addr[1:0] == 2'b00));

endmodule : vec_lsu_ctrl

// ==== verilog/axi4_burst_master.sv ====
`timescale 1ns/1ps

module axi4_burst_master (
   input  logic                clk,
   input  logic                rst_n,
   vec_burst_if.master         bp,
   output logic                awvalid,
   output vmem_pkg::mem_addr_t awaddr,
   output vmem_pkg::axi_len_t  awlen,
   input  logic                awready,
   output logic                wvalid,
   output vmem_pkg::mem_data_t wdata,
   output logic                wlast,
   input  logic                wready,
   input  logic                bvalid,
   output logic                bready,
   output logic                arvalid,
   output vmem_pkg::mem_addr_t araddr,
   output vmem_pkg::axi_len_t  arlen,
   input  logic                arready,
   input  logic                rvalid,
   input  vmem_pkg::mem_data_t rdata,
   input  logic                rlast,
   output logic                rready
);

   import vmem_pkg::*;

   axi_len_t beat;

   // write data comes straight from the register bank
   assign wdata = bp.wdata;

   assign bp.wnext = wvalid && wready;
   assign bp.rnext = rvalid && rready;
   assign bp.rdata = rdata;
   assign bp.fin   = (bvalid && bready) || (rvalid && rready && rlast);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
         wlast   <= 1'b0;
         bready  <= 1'b0;
         arvalid <= 1'b0;
         rready  <= 1'b0;
         beat    <= '0;
      end else begin
         if (bp.req) begin
            beat <= '0;
            if (bp.write) begin
               awvalid <= 1'b1;
               wvalid  <= 1'b1;
               wlast   <= (bp.len == '0);
            end else begin
               arvalid <= 1'b1;
               rready  <= 1'b1;
            end
         end
         if (awvalid && awready) begin
            awvalid <= 1'b0;
         end
         if (arvalid && arready) begin
            arvalid <= 1'b0;
         end
         // write beats, then wait on the response
         if (wvalid && wready) begin
            if (wlast) begin
               wvalid <= 1'b0;
               wlast  <= 1'b0;
               bready <= 1'b1;
            end else begin
               beat  <= beat + 1'b1;
               wlast <= (beat + 1'b1 == awlen);
            end
         end
         if (bvalid && bready) begin
            bready <= 1'b0;
         end
         if (rvalid && rready && rlast) begin
            rready <= 1'b0;
         end
      end
   end

   // address and length are payload, only loaded on a request
   always_ff @(posedge clk) begin
      if (bp.req && bp.write) begin
         awaddr <= bp.addr;
         awlen  <= bp.len;
      end
      if (bp.req && !bp.write) begin
         araddr <= bp.addr;
         arlen  <= bp.len;
      end
   end

   a_aw_hold : assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

   a_ar_hold : assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

   a_w_hold : assert property (@(posedge clk) disable iff (!rst_n)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast));

   // last flag only on the beat numbered awlen
   a_wlast_final : assert property (@(posedge clk) disable iff (!rst_n)
      wvalid |-> (wlast == (beat == awlen)));

endmodule : axi4_burst_master

// ==== verilog/vec_mem_top.sv ====
`timescale 1ns/1ps

module vec_mem_top #(
   parameter int NUM_VREGS = 8,
   parameter int VLMAX     = 8
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  instr_valid,
   input  vinstr_pkg::vop_t      instr_op,
   input  vinstr_pkg::vreg_idx_t instr_vreg,
   input  vmem_pkg::mem_addr_t   instr_addr,
   input  logic                  cfg_we,
   input  vinstr_pkg::vlen_t     cfg_vlen,
   output logic                  busy,
   output logic                  done,
   output logic                  dropped,
   output logic                  awvalid,
   output vmem_pkg::mem_addr_t   awaddr,
   output vmem_pkg::axi_len_t    awlen,
   input  logic                  awready,
   output logic                  wvalid,
   output vmem_pkg::mem_data_t   wdata,
   output logic                  wlast,
   input  logic                  wready,
   input  logic                  bvalid,
   output logic                  bready,
   output logic                  arvalid,
   output vmem_pkg::mem_addr_t   araddr,
   output vmem_pkg::axi_len_t    arlen,
   input  logic                  arready,
   input  logic                  rvalid,
   input  vmem_pkg::mem_data_t   rdata,
   input  logic                  rlast,
   output logic                  rready
);

   import vinstr_pkg::*;

   vlen_t vlen;
   logic  drop;

   vec_burst_if burst_if0 ();
   vreg_port_if vreg_if0 ();

   vec_cfg_regs #(
      .VLMAX (VLMAX)
   ) cfg0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .cfg_we   (cfg_we),
      .cfg_vlen (cfg_vlen),
      .busy     (busy),
      .drop     (drop),
      .vlen     (vlen),
      .dropped  (dropped)
   );

   vec_reg_bank #(
      .NUM_VREGS (NUM_VREGS),
      .VLMAX     (VLMAX)
   ) bank0 (
      .clk   (clk),
      .rst_n (rst_n),
      .vp    (vreg_if0.bank)
   );

   vec_lsu_ctrl lsu0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr_op    (instr_op),
      .instr_vreg  (instr_vreg),
      .instr_addr  (instr_addr),
      .vlen        (vlen),
      .busy        (busy),
      .done        (done),
      .drop        (drop),
      .vp          (vreg_if0.ctrl),
      .bp          (burst_if0.ctrl)
   );

   axi4_burst_master axi0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .bp      (burst_if0.master),
      .awvalid (awvalid),
      .awaddr  (awaddr),
      .awlen   (awlen),
      .awready (awready),
      .wvalid  (wvalid),
      .wdata   (wdata),
      .wlast   (wlast),
      .wready  (wready),
      .bvalid  (bvalid),
      .bready  (bready),
      .arvalid (arvalid),
      .araddr  (araddr),
      .arlen   (arlen),
      .arready (arready),
      .rvalid  (rvalid),
      .rdata   (rdata),
      .rlast   (rlast),
      .rready  (rready)
   );

endmodule : vec_mem_top

// ==== tests/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model #(
   parameter int SEED = 32'h2b27ac31
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                awvalid,
   input  vmem_pkg::mem_addr_t awaddr,
   input  vmem_pkg::axi_len_t  awlen,
   output logic                awready,
   input  logic                wvalid,
   input  vmem_pkg::mem_data_t wdata,
   input  logic                wlast,
   output logic                wready,
   output logic                bvalid,
   input  logic                bready,
   input  logic                arvalid,
   input  vmem_pkg::mem_addr_t araddr,
   input  vmem_pkg::axi_len_t  arlen,
   output logic                arready,
   output logic                rvalid,
   output vmem_pkg::mem_data_t rdata,
   output logic                rlast,
   input  logic                rready,
   output int                  burst_count,
   output logic                last_write,
   output vmem_pkg::axi_len_t  last_len,
   output vmem_pkg::mem_addr_t last_addr
);

   import vmem_pkg::*;

   mem_data_t  mem [256];
   integer     seed;
   logic       rst_s;
   logic       aw_fire, w_fire, b_fire, ar_fire, r_fire;
   logic       rd_active, wr_active, b_pend;
   logic [7:0] rd_idx, wr_idx;
   axi_len_t   rd_beat, rd_len, wr_beat;

   // ready or valid with about three chances in four
   function automatic logic ready_draw();
      return (($random(seed) & 3) != 0);
   endfunction

   initial begin
      seed        = SEED;
      awready     = 1'b0;
      wready      = 1'b0;
      bvalid      = 1'b0;
      arready     = 1'b0;
      rvalid      = 1'b0;
      rdata       = '0;
      rlast       = 1'b0;
      burst_count = 0;
      last_write  = 1'b0;
      last_len    = '0;
      last_addr   = '0;
      rd_active   = 1'b0;
      wr_active   = 1'b0;
      b_pend      = 1'b0;
      for (int i = 0; i < 256; i++) begin
         // pattern mixes every bit of the word index
         mem[i] = 32'h5a00_0000 ^ (i << 16) ^ (i * 32'h0000_0a53);
      end
   end

   always begin
      // bookkeeping mid-cycle, where all channel signals are settled
      @(negedge clk);
      rst_s   = rst_n;
      aw_fire = awvalid && awready;
      w_fire  = wvalid && wready;
      b_fire  = bvalid && bready;
      ar_fire = arvalid && arready;
      r_fire  = rvalid && rready;
      if (!rst_s) begin
         rd_active = 1'b0;
         wr_active = 1'b0;
         b_pend    = 1'b0;
      end else begin
         if (ar_fire) begin
            rd_active   = 1'b1;
            rd_idx      = araddr[9:2];
            rd_len      = arlen;
            rd_beat     = '0;
            burst_count = burst_count + 1;
            last_write  = 1'b0;
            last_len    = arlen;
            last_addr   = araddr;
         end
         if (r_fire) begin
            rd_active = !rlast;
            rd_beat   = rd_beat + 1'b1;
         end
         if (aw_fire) begin
            wr_active   = 1'b1;
            wr_idx      = awaddr[9:2];
            wr_beat     = '0;
            burst_count = burst_count + 1;
            last_write  = 1'b1;
            last_len    = awlen;
            last_addr   = awaddr;
         end
         if (w_fire) begin
            mem[wr_idx + wr_beat] = wdata;
            wr_beat = wr_beat + 1'b1;
            if (wlast) begin
               wr_active = 1'b0;
               b_pend    = 1'b1;
            end
         end
         if (b_fire) begin
            b_pend = 1'b0;
         end
      end
      @(posedge clk);
      #1;
      if (!rst_s) begin
         awready = 1'b0;
         wready  = 1'b0;
         bvalid  = 1'b0;
         arready = 1'b0;
         rvalid  = 1'b0;
         rlast   = 1'b0;
      end else begin
         arready = ready_draw();
         awready = ready_draw();
         wready  = wr_active && ready_draw();
         // a raised valid holds until it is taken
         if (!rvalid || r_fire) begin
            rvalid = rd_active && ready_draw();
            rdata  = mem[rd_idx + rd_beat];
            rlast  = (rd_beat == rd_len);
         end
         if (!bvalid || b_fire) begin
            bvalid = b_pend && ready_draw();
         end
      end
   end

endmodule : axi_mem_model

// ==== tests/vec_mem_tb.sv ====
`timescale 1ns/1ps

module vec_mem_tb;

   import vmem_pkg::*;
   import vinstr_pkg::*;

   localparam int SEED = 32'h2b27ac31;

   logic      clk;
   logic      rst_n;
   logic      instr_valid;
   vop_t      instr_op;
   vreg_idx_t instr_vreg;
   mem_addr_t instr_addr;
   logic      cfg_we;
   vlen_t     cfg_vlen;
   logic      busy, done, dropped;
   logic      awvalid, awready, wvalid, wlast, wready, bvalid, bready;
   logic      arvalid, arready, rvalid, rlast, rready;
   mem_addr_t awaddr, araddr;
   axi_len_t  awlen, arlen;
   mem_data_t wdata, rdata;
   int        burst_count;
   logic      last_write;
   axi_len_t  last_len;
   mem_addr_t last_addr;

   // reference model state
   integer    seed;
   mem_data_t ref_mem [256];
   mem_data_t ref_regs [8][8];
   vlen_t     ref_vlen;
   logic      ref_dropped;
   mem_addr_t exp_addr;
   int        accepted;
   int        done_count;
   logic      busy_prev;
   logic      done_prev;

   vec_mem_top #(
      .NUM_VREGS (8),
      .VLMAX     (8)
   ) dut0 (.*);

   axi_mem_model #(
      .SEED (SEED)
   ) mem0 (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "address mismatch");
      end
   endtask

   task automatic check_len(input string name, input axi_len_t exp, input axi_len_t act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "length mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("%0t %s", $time, why);
      $display("Simulation FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic next_slot();
      @(posedge clk);
      #1;
   endtask

   // word index leaving room for a full vector
   function automatic int pick_idx();
      return {$random(seed)} % 248;
   endfunction

   function automatic int pick_other(input int src);
      return (src + 8 + ({$random(seed)} % 232)) % 248;
   endfunction

   function automatic vreg_idx_t pick_vreg();
      return vreg_idx_t'($random(seed));
   endfunction

   task automatic issue_instr(input vop_t op, input vreg_idx_t vreg, input int idx);
      next_slot();
      instr_valid = 1'b1;
      instr_op    = op;
      instr_vreg  = vreg;
      instr_addr  = mem_addr_t'(idx) << 2;
      exp_addr    = mem_addr_t'(idx * 4);
      next_slot();
      instr_valid = 1'b0;
      accepted    = accepted + 1;
      for (int k = 0; k < ref_vlen; k++) begin
         if (op == VOP_LOAD) begin
            ref_regs[vreg][k] = ref_mem[idx + k];
         end else begin
            ref_mem[idx + k] = ref_regs[vreg][k];
         end
      end
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n = n + 1;
      end while (!done && n < 500);
      if (!done) begin
         abort_run("timeout after 500 cycles waiting for done");
      end
   endtask

   task automatic finish_instr(input vop_t op);
      wait_done();
      if (burst_count != accepted) begin
         abort_run("AXI burst count differs from the accepted instruction count");
      end
      check_flag("burst_write", op == VOP_STORE, last_write);
      check_addr(op == VOP_LOAD ? "araddr" : "awaddr", exp_addr, last_addr);
      check_len(op == VOP_LOAD ? "arlen" : "awlen", axi_len_t'(int'(ref_vlen) - 1),
                last_len);
      for (int i = 0; i < 256; i++) begin
         check_data($sformatf("mem[%0d]", i), ref_mem[i], mem0.mem[i]);
      end
      for (int r = 0; r < 8; r++) begin
         for (int e = 0; e < 8; e++) begin
            check_data($sformatf("vreg%0d[%0d]", r, e), ref_regs[r][e], dut0.bank0.regs[r][e]);
         end
      end
      check_flag("dropped", ref_dropped, dropped);
   endtask

   task automatic run_move(input vop_t op, input vreg_idx_t vreg, input int idx);
      issue_instr(op, vreg, idx);
      finish_instr(op);
   endtask

   task automatic set_vlen(input vlen_t v);
      next_slot();
      cfg_we   = 1'b1;
      cfg_vlen = v;
      next_slot();
      cfg_we   = 1'b0;
      ref_vlen = v;
   endtask

   // done must be a single pulse on the edge where busy falls
   always @(negedge clk) begin
      if (rst_n && done) begin
         check_flag("busy", 1'b0, busy);
         check_flag("busy_before_done", 1'b1, busy_prev);
         check_flag("done_before_done", 1'b0, done_prev);
         done_count = done_count + 1;
      end
      busy_prev = busy;
      done_prev = done;
   end

   initial begin
      vreg_idx_t vreg;
      int        src;
      seed        = SEED;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr_op    = VOP_LOAD;
      instr_vreg  = '0;
      instr_addr  = '0;
      cfg_we      = 1'b0;
      cfg_vlen    = '0;
      accepted    = 0;
      done_count  = 0;
      ref_vlen    = vlen_t'(8);
      ref_dropped = 1'b0;
      for (int r = 0; r < 8; r++) begin
         for (int e = 0; e < 8; e++) begin
            ref_regs[r][e] = '0;
         end
      end
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = mem0.mem[i];
      end

      // idle outputs straight out of reset
      @(negedge clk);
      check_flag("busy", 1'b0, busy);
      check_flag("done", 1'b0, done);
      check_flag("dropped", 1'b0, dropped);
      check_flag("awvalid", 1'b0, awvalid);
      check_flag("wvalid", 1'b0, wvalid);
      check_flag("arvalid", 1'b0, arvalid);
      check_flag("rready", 1'b0, rready);
      check_flag("bready", 1'b0, bready);
      run_move(VOP_STORE, pick_vreg(), pick_idx());

      // load then store the same register elsewhere, full length
      repeat (6) begin
         vreg = pick_vreg();
         src  = pick_idx();
         run_move(VOP_LOAD, vreg, src);
         run_move(VOP_STORE, vreg, pick_other(src));
      end

      // random lengths from 1 to 8
      repeat (6) begin
         set_vlen(vlen_t'(({$random(seed)} % 8) + 1));
         vreg = pick_vreg();
         src  = pick_idx();
         run_move(VOP_LOAD, vreg, src);
         run_move(VOP_STORE, vreg, pick_other(src));
      end

      // second strobe lands while busy and must be discarded
      issue_instr(VOP_LOAD, pick_vreg(), pick_idx());
      instr_valid = 1'b1;
      instr_op    = VOP_STORE;
      instr_vreg  = pick_vreg();
      instr_addr  = mem_addr_t'(pick_idx()) << 2;
      next_slot();
      instr_valid = 1'b0;
      ref_dropped = 1'b1;
      finish_instr(VOP_LOAD);

      // length write during a burst is ignored
      issue_instr(VOP_STORE, pick_vreg(), pick_idx());
      cfg_we   = 1'b1;
      cfg_vlen = vlen_t'((ref_vlen % 8) + 1);
      next_slot();
      cfg_we   = 1'b0;
      finish_instr(VOP_STORE);
      run_move(VOP_LOAD, pick_vreg(), pick_idx());

      repeat (3) @(negedge clk);
      if (done_count != accepted) begin
         abort_run($sformatf("saw %0d done pulses for %0d accepted instructions",
                             done_count, accepted));
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule : vec_mem_tb

// ==== vec_mem_top.f ====
verilog/vmem_pkg.sv
verilog/vinstr_pkg.sv
verilog/vec_burst_if.sv
verilog/vreg_port_if.sv
verilog/vec_cfg_regs.sv
verilog/vec_reg_bank.sv
verilog/vec_lsu_ctrl.sv
verilog/axi4_burst_master.sv
verilog/vec_mem_top.sv
tests/axi_mem_model.sv
tests/vec_mem_tb.sv
